// ==== design/switch_config.svh ====
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// output ports served from the shared buffer
`define SW_PORTS 4

// page geometry, in 16-bit half-words
`define SW_PAGE_WORDS 8
`define SW_PAGES 64

// largest packet is 64 words
`define SW_MAX_PKT_PAGES 8

// free-page thresholds for the write side levels
`define SW_FULL_PAGES `SW_MAX_PKT_PAGES
`define SW_AFULL_PAGES 16

`endif

// ==== design/switch_pkg.sv ====
package switch_pkg;

    typedef logic [15:0] word_t;
    typedef logic [5:0] page_t;
    typedef logic [2:0] beat_t;
    typedef logic [1:0] port_t;
    // 0 to 64 pages
    typedef logic [6:0] page_cnt_t;

    // one stored half-word with its end-of-packet mark
    typedef struct packed {
        word_t data;
        logic  last;
    } mem_word_t;

    typedef struct packed {
        page_t page;
        beat_t beat;
    } mem_addr_t;

    // jump table update, page from links to page to
    typedef struct packed {
        logic  en;
        page_t from;
        page_t to;
    } link_wr_t;

    // finished packet handed to an output queue
    typedef struct packed {
        logic  en;
        port_t port;
        page_t head;
    } enq_t;

    typedef enum logic {WR_IDLE, WR_STORE} wr_state_t;
    typedef enum logic {RD_IDLE, RD_STREAM} rd_state_t;

endpackage

// ==== design/free_page_list.sv ====
`timescale 1ns/1ps
`include "switch_config.svh"

module free_page_list (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pop,
    input  logic                  push,
    input  switch_pkg::page_t     push_page,
    output switch_pkg::page_t     head_page,
    output switch_pkg::page_cnt_t free_count,
    output logic                  full,
    output logic                  almost_full
);
    import switch_pkg::*;

    page_t                 slots [`SW_PAGES];
    logic [`SW_PAGES-1:0]  written;
    page_t                 rd_ptr;
    page_t                 wr_ptr;

    // a slot never refilled still holds its reset page, which equals its index
    assign head_page = written[rd_ptr] ? slots[rd_ptr] : rd_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            written     <= '0;
            free_count  <= page_cnt_t'(`SW_PAGES);
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push) begin
                wr_ptr          <= wr_ptr + 1'b1;
                written[wr_ptr] <= 1'b1;
            end
            case ({push, pop})
                2'b10:   free_count <= free_count + 1'b1;
                2'b01:   free_count <= free_count - 1'b1;
                default: free_count <= free_count;
            endcase
            // levels follow the count one cycle late
            full        <= free_count < page_cnt_t'(`SW_FULL_PAGES);
            almost_full <= free_count < page_cnt_t'(`SW_AFULL_PAGES);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            slots[wr_ptr] <= push_page;
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> free_count != '0);
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> free_count < page_cnt_t'(`SW_PAGES));

endmodule

// ==== design/packet_memory.sv ====
`timescale 1ns/1ps
`include "switch_config.svh"

module packet_memory (
    input  logic                  clk,
    input  logic                  wr_en,
    input  switch_pkg::mem_addr_t wr_addr,
    input  switch_pkg::mem_word_t wr_word,
    input  logic                  rd_en,
    input  switch_pkg::mem_addr_t rd_addr,
    output switch_pkg::mem_word_t rd_word,
    input  switch_pkg::link_wr_t  link_wr,
    input  switch_pkg::page_t     link_page,
    output switch_pkg::page_t     link_next
);
    import switch_pkg::*;

    // word store, page number in the upper address bits
    mem_word_t words [`SW_PAGES * `SW_PAGE_WORDS];
    // next page of the same packet
    page_t     jump  [`SW_PAGES];

    always_ff @(posedge clk) begin
        if (wr_en)
            words[wr_addr] <= wr_word;
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_word <= words[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (link_wr.en)
            jump[link_wr.from] <= link_wr.to;
    end

    // combinational so the reader can hop pages without a bubble
    assign link_next = jump[link_page];

endmodule

// ==== design/output_queues.sv ====
`timescale 1ns/1ps
`include "switch_config.svh"

module output_queues (
    input  logic                                clk,
    input  logic                                rst_n,
    input  switch_pkg::enq_t                    enq,
    input  logic                                deq,
    input  switch_pkg::port_t                   deq_port,
    output logic [`SW_PORTS-1:0]                not_empty,
    output switch_pkg::page_t [`SW_PORTS-1:0]   head_pages
);
    import switch_pkg::*;

    // head page of each queued packet, in arrival order per port
    page_t                slots  [`SW_PORTS][`SW_PAGES];
    page_t                wr_ptr [`SW_PORTS];
    page_t                rd_ptr [`SW_PORTS];
    page_cnt_t            count  [`SW_PORTS];
    logic [`SW_PORTS-1:0] push;
    logic [`SW_PORTS-1:0] pop;

    always_comb begin
        for (int p = 0; p < `SW_PORTS; p++) begin
            push[p]       = enq.en && (enq.port == port_t'(p));
            pop[p]        = deq && (deq_port == port_t'(p));
            not_empty[p]  = count[p] != '0;
            head_pages[p] = slots[p][rd_ptr[p]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
        end else begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                if (push[p])
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                if (pop[p])
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                if (push[p] && !pop[p])
                    count[p] <= count[p] + 1'b1;
                else if (pop[p] && !push[p])
                    count[p] <= count[p] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `SW_PORTS; p++) begin
            if (push[p])
                slots[p][wr_ptr[p]] <= enq.head;
        end
    end

    a_no_deq_empty: assert property (@(posedge clk) disable iff (!rst_n)
        deq |-> not_empty[deq_port]);

endmodule

// ==== design/port_scan_counter.sv ====
`timescale 1ns/1ps
`include "switch_config.svh"

module port_scan_counter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  logic [`SW_PORTS-1:0] eligible,
    output switch_pkg::port_t    port,
    output logic                 found
);
    import switch_pkg::*;

    port_t start_q;
    port_t idx;

    // first eligible port at or after the start pointer
    always_comb begin
        found = 1'b0;
        port  = start_q;
        idx   = start_q;
        for (int i = 0; i < `SW_PORTS; i++) begin
            idx = start_q + port_t'(i);
            if (!found && eligible[idx]) begin
                found = 1'b1;
                port  = idx;
            end
        end
    end

    // next scan begins just past the port served
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            start_q <= '0;
        else if (advance)
            start_q <= port + 1'b1;
    end

endmodule

// ==== design/write_ctrl.sv ====
`timescale 1ns/1ps

module write_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  switch_pkg::word_t     wr_data,
    input  switch_pkg::page_t     free_head,
    output logic                  pop,
    output logic                  mem_wr_en,
    output switch_pkg::mem_addr_t mem_wr_addr,
    output switch_pkg::mem_word_t mem_wr_word,
    output switch_pkg::link_wr_t  link_wr,
    output switch_pkg::enq_t      enq
);
    import switch_pkg::*;

    wr_state_t state;
    beat_t     beat_q;
    page_t     cur_page;
    page_t     head_q;
    port_t     dest_q;
    logic      accept;
    logic      new_page;

    // words outside a packet are dropped
    assign accept   = wr_vld && (state == WR_STORE || wr_sop);
    assign new_page = accept && (beat_q == '0);
    assign pop      = new_page;
    assign mem_wr_en = accept;

    always_comb begin
        mem_wr_addr.page = new_page ? free_head : cur_page;
        mem_wr_addr.beat = beat_q;
        mem_wr_word.data = wr_data;
        mem_wr_word.last = wr_eop;
        // chain the page just filled to the one taken now
        link_wr.en       = new_page && !wr_sop;
        link_wr.from     = cur_page;
        link_wr.to       = free_head;
        enq.en           = accept && wr_eop;
        enq.port         = wr_sop ? wr_data[1:0] : dest_q;
        enq.head         = wr_sop ? free_head : head_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= WR_IDLE;
            beat_q <= '0;
        end else if (accept) begin
            beat_q <= wr_eop ? beat_t'(0) : beat_q + 1'b1;
            state  <= wr_eop ? WR_IDLE : WR_STORE;
        end
    end

    always_ff @(posedge clk) begin
        if (new_page)
            cur_page <= free_head;
        if (accept && wr_sop) begin
            head_q <= free_head;
            dest_q <= wr_data[1:0];
        end
    end

    a_no_sop_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
        state == WR_STORE |-> !(wr_vld && wr_sop));

endmodule

// ==== design/read_ctrl.sv ====
`timescale 1ns/1ps
`include "switch_config.svh"

module read_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [`SW_PORTS-1:0]              ready,
    input  logic [`SW_PORTS-1:0]              not_empty,
    input  switch_pkg::page_t [`SW_PORTS-1:0] head_pages,
    input  switch_pkg::port_t                 scan_port,
    input  logic                              scan_found,
    output logic                              scan_advance,
    output logic [`SW_PORTS-1:0]              eligible,
    output logic                              deq,
    output switch_pkg::port_t                 deq_port,
    output logic                              mem_rd_en,
    output switch_pkg::mem_addr_t             mem_rd_addr,
    input  switch_pkg::mem_word_t             rd_word,
    output switch_pkg::page_t                 link_page,
    input  switch_pkg::page_t                 link_next,
    output logic                              free_push,
    output switch_pkg::page_t                 free_page,
    output logic [`SW_PORTS-1:0]              rd_sop,
    output logic [`SW_PORTS-1:0]              rd_eop,
    output logic [`SW_PORTS-1:0]              rd_vld,
    output switch_pkg::word_t [`SW_PORTS-1:0] rd_data
);
    import switch_pkg::*;

    localparam beat_t LAST_BEAT = beat_t'(`SW_PAGE_WORDS - 1);

    rd_state_t state;
    port_t     cur_port;
    page_t     page_q;
    beat_t     beat_q;
    logic      first_q;
    // word coming out of the memory this cycle
    logic      rsp_vld;
    logic      rsp_first;
    page_t     rsp_page;
    beat_t     rsp_beat;
    logic      start;
    logic      end_now;

    assign eligible     = (state == RD_IDLE) ? not_empty : '0;
    assign start        = (state == RD_IDLE) && scan_found;
    assign scan_advance = start;
    assign deq          = start;
    assign deq_port     = scan_port;

    // the last word is only known once it returns, so stop issuing then
    assign end_now   = rsp_vld && rd_word.last;
    assign mem_rd_en = (state == RD_STREAM) && ready[cur_port] && !end_now;

    always_comb begin
        mem_rd_addr.page = page_q;
        mem_rd_addr.beat = beat_q;
    end
    assign link_page = page_q;

    // page done after its final beat or the packet end
    assign free_push = rsp_vld && (rsp_beat == LAST_BEAT || rd_word.last);
    assign free_page = rsp_page;

    always_comb begin
        rd_vld = '0;
        rd_sop = '0;
        rd_eop = '0;
        rd_vld[cur_port] = rsp_vld;
        rd_sop[cur_port] = rsp_vld && rsp_first;
        rd_eop[cur_port] = end_now;
        for (int p = 0; p < `SW_PORTS; p++)
            rd_data[p] = rd_word.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RD_IDLE;
            first_q   <= 1'b0;
            rsp_vld   <= 1'b0;
            rsp_first <= 1'b0;
        end else begin
            rsp_vld   <= mem_rd_en;
            rsp_first <= mem_rd_en && first_q;
            if (start)
                first_q <= 1'b1;
            else if (mem_rd_en)
                first_q <= 1'b0;
            case (state)
                RD_IDLE:   if (start) state <= RD_STREAM;
                RD_STREAM: if (end_now) state <= RD_IDLE;
                default:   state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_port <= scan_port;
            page_q   <= head_pages[scan_port];
            beat_q   <= '0;
        end else if (mem_rd_en) begin
            beat_q <= beat_q + 1'b1;
            // hop to the next page of this packet
            if (beat_q == LAST_BEAT)
                page_q <= link_next;
        end
        if (mem_rd_en) begin
            rsp_page <= page_q;
            rsp_beat <= beat_q;
        end
    end

endmodule

// ==== design/shared_buffer_switch.sv ====
`timescale 1ns/1ps
`include "switch_config.svh"

module shared_buffer_switch (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_sop,
    input  logic                              wr_eop,
    input  logic                              wr_vld,
    input  switch_pkg::word_t                 wr_data,
    output logic                              full,
    output logic                              almost_full,
    input  logic [`SW_PORTS-1:0]              ready,
    output logic [`SW_PORTS-1:0]              rd_sop,
    output logic [`SW_PORTS-1:0]              rd_eop,
    output logic [`SW_PORTS-1:0]              rd_vld,
    output switch_pkg::word_t [`SW_PORTS-1:0] rd_data
);
    import switch_pkg::*;

    page_t                free_head;
    logic                 free_pop;
    logic                 free_push;
    page_t                free_page;
    logic                 mem_wr_en;
    mem_addr_t            mem_wr_addr;
    mem_word_t            mem_wr_word;
    logic                 mem_rd_en;
    mem_addr_t            mem_rd_addr;
    mem_word_t            mem_rd_word;
    link_wr_t             link_wr;
    page_t                link_page;
    page_t                link_next;
    enq_t                 enq;
    logic                 deq;
    port_t                deq_port;
    logic [`SW_PORTS-1:0] not_empty;
    page_t [`SW_PORTS-1:0] head_pages;
    logic                 scan_advance;
    logic [`SW_PORTS-1:0] eligible;
    port_t                scan_port;
    logic                 scan_found;

    free_page_list u_free_page_list (
        .clk(clk), .rst_n(rst_n), .pop(free_pop), .push(free_push),
        .push_page(free_page), .head_page(free_head), .free_count(),
        .full(full), .almost_full(almost_full)
    );

    packet_memory u_packet_memory (
        .clk(clk), .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_word(mem_wr_word),
        .rd_en(mem_rd_en), .rd_addr(mem_rd_addr), .rd_word(mem_rd_word),
        .link_wr(link_wr), .link_page(link_page), .link_next(link_next)
    );

    output_queues u_output_queues (
        .clk(clk), .rst_n(rst_n), .enq(enq), .deq(deq), .deq_port(deq_port),
        .not_empty(not_empty), .head_pages(head_pages)
    );

    port_scan_counter u_port_scan_counter (
        .clk(clk), .rst_n(rst_n), .advance(scan_advance), .eligible(eligible),
        .port(scan_port), .found(scan_found)
    );

    write_ctrl u_write_ctrl (
        .clk(clk), .rst_n(rst_n), .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld),
        .wr_data(wr_data), .free_head(free_head), .pop(free_pop),
        .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_word(mem_wr_word),
        .link_wr(link_wr), .enq(enq)
    );

    read_ctrl u_read_ctrl (
        .clk(clk), .rst_n(rst_n), .ready(ready), .not_empty(not_empty),
        .head_pages(head_pages), .scan_port(scan_port), .scan_found(scan_found),
        .scan_advance(scan_advance), .eligible(eligible), .deq(deq),
        .deq_port(deq_port), .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr),
        .rd_word(mem_rd_word), .link_page(link_page), .link_next(link_next),
        .free_push(free_push), .free_page(free_page), .rd_sop(rd_sop),
        .rd_eop(rd_eop), .rd_vld(rd_vld), .rd_data(rd_data)
    );

endmodule

// ==== tests/tb_shared_buffer_switch.sv ====
`timescale 1ns/1ps
`include "switch_config.svh"

module tb_shared_buffer_switch;
    import switch_pkg::*;

    // words sent per test with the back-pressure test counted twice
    localparam int TEST_WORDS  = 17 + 93 + 2 * 144 + 435;
    localparam int WATCHDOG_NS = (TEST_WORDS * 4 + 500) * 20;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     wr_sop;
    logic                     wr_eop;
    logic                     wr_vld;
    word_t                    wr_data;
    logic                     full;
    logic                     almost_full;
    logic [`SW_PORTS-1:0]     ready = '0;
    logic [`SW_PORTS-1:0]     rd_sop;
    logic [`SW_PORTS-1:0]     rd_eop;
    logic [`SW_PORTS-1:0]     rd_vld;
    word_t [`SW_PORTS-1:0]    rd_data;

    integer                   seed = 32'h3eca_36d9;
    int                       errors = 0;
    int                       checks = 0;
    logic [`SW_PORTS-1:0]     ready_hold = '0;
    logic [`SW_PORTS-1:0]     ready_draw = '0;
    logic                     random_ready = 1'b0;
    logic [`SW_PORTS-1:0]     prev_ready = '0;
    // expected words per port as {sop, eop, data}
    logic [17:0]              exp_q [`SW_PORTS][$];

    shared_buffer_switch u_shared_buffer_switch (
        .clk(clk), .rst_n(rst_n), .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld),
        .wr_data(wr_data), .full(full), .almost_full(almost_full), .ready(ready),
        .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld), .rd_data(rd_data)
    );

    always #10 clk = ~clk;

    // random ready pattern for the next rising edge
    always @(negedge clk) begin
        ready_draw = 4'($random(seed));
    end

    always @(posedge clk) begin
        ready <= random_ready ? ready_draw : ready_hold;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: actual %h expected %h", name, actual, expected);
        end
    endtask

    function automatic bit queues_empty();
        bit empty;
        empty = 1'b1;
        for (int p = 0; p < `SW_PORTS; p++)
            if (exp_q[p].size() != 0)
                empty = 1'b0;
        return empty;
    endfunction

    // compare delivered words per port
    always @(negedge clk) begin : monitor
        logic [17:0] e;
        if (rst_n) begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                if (rd_vld[p] && !prev_ready[p]) begin
                    errors++;
                    $display("port %0d delivered a word one cycle after ready was low", p);
                end
                if (rd_vld[p] && exp_q[p].size() == 0) begin
                    errors++;
                    $display("port %0d delivered a word that was never sent", p);
                end else if (rd_vld[p]) begin
                    e = exp_q[p].pop_front();
                    check($sformatf("rd_data[%0d]", p), 32'(rd_data[p]), 32'(e[15:0]));
                    check($sformatf("rd_sop[%0d]", p), 32'(rd_sop[p]), 32'(e[17]));
                    check($sformatf("rd_eop[%0d]", p), 32'(rd_eop[p]), 32'(e[16]));
                end
            end
            check("rd_sop", 32'(rd_sop & ~rd_vld), 32'(0));
            check("rd_eop", 32'(rd_eop & ~rd_vld), 32'(0));
        end
        prev_ready = ready;
    end

    // first word carries the port in its low bits
    task automatic send_packet(input port_t port, input int len);
        word_t w;
        logic  sop;
        logic  eop;
        @(negedge clk);
        while (full)
            @(negedge clk);
        @(posedge clk);
        for (int i = 0; i < len; i++) begin
            w = 16'($random(seed));
            sop = (i == 0);
            eop = (i == len - 1);
            if (sop)
                w[1:0] = port;
            wr_vld  <= 1'b1;
            wr_sop  <= sop;
            wr_eop  <= eop;
            wr_data <= w;
            exp_q[port].push_back({sop, eop, w});
            @(posedge clk);
        end
        wr_vld <= 1'b0;
        wr_sop <= 1'b0;
        wr_eop <= 1'b0;
    endtask

    task automatic set_ready(input logic [`SW_PORTS-1:0] value);
        @(posedge clk);
        ready_hold <= value;
        repeat (2) @(posedge clk);
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (!queues_empty() && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (!queues_empty()) begin
            errors++;
            $display("output ports did not deliver all words within %0d cycles", max_cycles);
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check("full", 32'(full), 32'(0));
        check("almost_full", 32'(almost_full), 32'(0));
        check("rd_vld", 32'(rd_vld), 32'(0));
        check("rd_sop", 32'(rd_sop), 32'(0));
        check("rd_eop", 32'(rd_eop), 32'(0));
    endtask

    task automatic short_packet_per_port();
        set_ready('1);
        send_packet(2'd0, 1);
        send_packet(2'd1, 3);
        send_packet(2'd2, 5);
        send_packet(2'd3, 8);
        wait_drain(200);
    endtask

    task automatic packets_across_pages();
        send_packet(2'd1, 9);
        send_packet(2'd2, 20);
        send_packet(2'd3, 64);
        wait_drain(400);
    endtask

    task automatic random_back_pressure();
        int len;
        @(posedge clk);
        random_ready <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            len = 1 + int'({$random(seed)} % 32'd24);
            send_packet(2'd2, len);
        end
        wait_drain(2000);
        @(posedge clk);
        random_ready <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic buffer_level_tracking();
        int lens [9] = '{64, 64, 64, 64, 64, 40, 17, 1, 57};
        int free_pages;
        int before_last;
        free_pages = `SW_PAGES;
        set_ready('0);
        for (int i = 0; i < 9; i++) begin
            send_packet(port_t'(i % `SW_PORTS), lens[i]);
            free_pages -= (lens[i] + `SW_PAGE_WORDS - 1) / `SW_PAGE_WORDS;
            // levels lag the count so a page taken by the last word shows one cycle late
            before_last = free_pages + (((lens[i] - 1) % `SW_PAGE_WORDS == 0) ? 1 : 0);
            @(negedge clk);
            check("full", 32'(full), 32'(before_last < `SW_FULL_PAGES));
            check("almost_full", 32'(almost_full), 32'(before_last < `SW_AFULL_PAGES));
            @(negedge clk);
            check("full", 32'(full), 32'(free_pages < `SW_FULL_PAGES));
            check("almost_full", 32'(almost_full), 32'(free_pages < `SW_AFULL_PAGES));
        end
        set_ready('1);
        wait_drain(2000);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("full", 32'(full), 32'(0));
        check("almost_full", 32'(almost_full), 32'(0));
    endtask

    initial begin
        rst_n   = 1'b0;
        wr_sop  = 1'b0;
        wr_eop  = 1'b0;
        wr_vld  = 1'b0;
        wr_data = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        short_packet_per_port();
        packets_across_pages();
        random_back_pressure();
        buffer_level_tracking();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/switch_pkg.sv
design/free_page_list.sv
design/packet_memory.sv
design/output_queues.sv
design/port_scan_counter.sv
design/write_ctrl.sv
design/read_ctrl.sv
design/shared_buffer_switch.sv
tests/tb_shared_buffer_switch.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_shared_buffer_switch
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard design/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
